//--- source/motorPkg.sv
package motorPkg;

    // width of the step period command, same as the m3freq pin
    localparam int freqWidth = 10;

    // shortest step allowed, in clk cycles
    // shorter requests are raised to this value
    localparam logic [freqWidth-1:0] freqMin = 10'd1000;

    // commutation step index, legal values 0 to 5
    typedef logic [2:0] stepT;

    // first and last step of the six-step cycle
    localparam stepT stepFirst = 3'd0;
    localparam stepT stepLast  = 3'd5;

    // sampled motor command
    typedef struct packed {
        // motor enabled
        logic                 run;
        // reverse rotation when set
        logic                 reverse;
        // step length in cycles, already clamped
        logic [freqWidth-1:0] period;
    } commandT;

    // gate requests, all active high
    // a set low-side field means that switch is on
    // pin polarity is applied only at the output stage
    typedef struct packed {
        logic aH;
        logic aL;
        logic bH;
        logic bL;
        logic cH;
        logic cL;
    } gateT;

    // every switch off
    localparam gateT gateOff = '0;

endpackage

//--- source/commandSync.sv
module commandSync (
    input  logic                                 clk,
    input  logic                                 nRst,
    // run level
    input  logic                                 m3start,
    // direction level, high for reverse
    input  logic                                 m3invOrStop,
    // requested step period in cycles
    input  logic [motorPkg::freqWidth-1:0]       m3freq,
    // registered and clamped command
    output motorPkg::commandT                    cmd
);

    // clamped period, ready for the register
    logic [motorPkg::freqWidth-1:0] periodClamped;

    // never let a step get shorter than freqMin
    always_comb begin
        if (m3freq > motorPkg::freqMin) begin
            periodClamped = m3freq;
        end else begin
            // equal or below the minimum
            periodClamped = motorPkg::freqMin;
        end
    end

    // single input register stage
    // all three commands sampled on the same edge
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            // stopped, forward, shortest period
            cmd.run     <= 1'b0;
            cmd.reverse <= 1'b0;
            cmd.period  <= motorPkg::freqMin;
        end else begin
            cmd.run     <= m3start;
            cmd.reverse <= m3invOrStop;
            cmd.period  <= periodClamped;
        end
    end

endmodule

//--- source/commutator.sv
module commutator (
    input  logic              clk,
    input  logic              nRst,
    // sampled command from the input stage
    input  motorPkg::commandT cmd,
    // gate pattern for the current step
    output motorPkg::gateT    gateReq
);

    // set one cycle after cmd.run rises, cleared one cycle after it falls
    logic                           active;
    // current commutation step
    motorPkg::stepT                 step;
    // following step, direction applied
    motorPkg::stepT                 stepNext;
    // cycles spent in the current step
    logic [motorPkg::freqWidth-1:0] cnt;
    // period in force for the current step
    logic [motorPkg::freqWidth-1:0] periodQ;
    // last cycle of the current step
    logic                           wrap;

    assign wrap = (cnt == periodQ - 1'b1);

    // six-step neighbour, wraps both ways
    always_comb begin
        if (cmd.reverse) begin
            if (step == motorPkg::stepFirst) begin
                stepNext = motorPkg::stepLast;
            end else begin
                stepNext = step - 1'b1;
            end
        end else begin
            if (step == motorPkg::stepLast) begin
                stepNext = motorPkg::stepFirst;
            end else begin
                stepNext = step + 1'b1;
            end
        end
    end

    // period counter and step sequencer
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            active  <= 1'b0;
            step    <= motorPkg::stepFirst;
            cnt     <= '0;
            periodQ <= motorPkg::freqMin;
        end else if (!cmd.run) begin
            // stopped, park on step 0
            active  <= 1'b0;
            step    <= motorPkg::stepFirst;
            cnt     <= '0;
            periodQ <= cmd.period;
        end else if (!active) begin
            // first running cycle, step 0 entered here
            active  <= 1'b1;
            cnt     <= '0;
            periodQ <= cmd.period;
        end else if (wrap) begin
            // step done, move on and pick up the new period
            cnt     <= '0;
            step    <= stepNext;
            periodQ <= cmd.period;
        end else begin
            cnt     <= cnt + 1'b1;
        end
    end

    // step to gate pattern
    // one high side and one low side, never on the same phase
    always_comb begin
        gateReq = motorPkg::gateOff;
        if (active) begin
            case (step)
                3'd0: begin
                    gateReq.aH = 1'b1;
                    gateReq.bL = 1'b1;
                end
                3'd1: begin
                    gateReq.aH = 1'b1;
                    gateReq.cL = 1'b1;
                end
                3'd2: begin
                    gateReq.bH = 1'b1;
                    gateReq.cL = 1'b1;
                end
                3'd3: begin
                    gateReq.bH = 1'b1;
                    gateReq.aL = 1'b1;
                end
                3'd4: begin
                    gateReq.cH = 1'b1;
                    gateReq.aL = 1'b1;
                end
                3'd5: begin
                    gateReq.cH = 1'b1;
                    gateReq.bL = 1'b1;
                end
                // 6 and 7 are unreachable, keep everything off
                default: gateReq = motorPkg::gateOff;
            endcase
        end
    end

endmodule

//--- source/pwmGenerator.sv
module pwmGenerator #(
    // frame length in cycles
    parameter int pwmPeriod = 16,
    // on cycles per frame
    parameter int pwmDuty   = 12
) (
    input  logic clk,
    input  logic nRst,
    // frame restarts from zero while low
    input  logic run,
    // chopping level, registered
    output logic pwm
);

    localparam int cntWidth = $clog2(pwmPeriod);

    // position inside the current frame
    logic [cntWidth-1:0] cnt;
    // frame end reached this cycle
    logic                frameEnd;

    assign frameEnd = (cnt == pwmPeriod - 1);

    // free-running frame counter
    // aligned to the first running cycle
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            cnt <= '0;
            pwm <= 1'b0;
        end else if (!run) begin
            // held at frame start, chopping off
            cnt <= '0;
            pwm <= 1'b0;
        end else begin
            // on for the first pwmDuty counts of each frame
            pwm <= (cnt < pwmDuty);
            if (frameEnd) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/gateDriver.sv
module gateDriver (
    input  logic           clk,
    input  logic           nRst,
    // gate requests, active high
    input  motorPkg::gateT gateReq,
    // chopping level
    input  logic           pwm,
    // high sides, active high on the pins
    output logic           aH,
    // low sides, active low on the pins
    output logic           aL,
    output logic           bH,
    output logic           bL,
    output logic           cH,
    output logic           cL
);

    // chopped requests, still active high
    motorPkg::gateT chopped;

    // pwm chops both sides of the bridge
    assign chopped = gateReq & {6{pwm}};

    // output register
    // low side flips to pin polarity only here
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            // every switch off
            aH <= 1'b0;
            bH <= 1'b0;
            cH <= 1'b0;
            aL <= 1'b1;
            bL <= 1'b1;
            cL <= 1'b1;
        end else begin
            aH <= chopped.aH;
            bH <= chopped.bH;
            cH <= chopped.cH;
            // a 0 on these pins turns the switch on
            aL <= ~chopped.aL;
            bL <= ~chopped.bL;
            cL <= ~chopped.cL;
        end
    end

endmodule

//--- source/motorTop.sv
module motorTop #(
    // pwm frame length and on time, in cycles
    parameter int pwmPeriod = 16,
    parameter int pwmDuty   = 12
) (
    input  logic                           clk,
    input  logic                           nRst,
    // commands, plain levels
    input  logic                           m3start,
    input  logic                           m3invOrStop,
    input  logic [motorPkg::freqWidth-1:0] m3freq,
    // bridge gates, highs active high, lows active low
    output logic                           aH,
    output logic                           aL,
    output logic                           bH,
    output logic                           bL,
    output logic                           cH,
    output logic                           cL
);

    // registered, clamped command
    motorPkg::commandT cmd;
    // step pattern before chopping
    motorPkg::gateT    gateReq;
    // chopping level
    logic              pwm;

    // input register and period clamp
    commandSync commandSync_i (
        .clk         (clk),
        .nRst        (nRst),
        .m3start     (m3start),
        .m3invOrStop (m3invOrStop),
        .m3freq      (m3freq),
        .cmd         (cmd)
    );

    // six-step sequencer
    commutator commutator_i (
        .clk     (clk),
        .nRst    (nRst),
        .cmd     (cmd),
        .gateReq (gateReq)
    );

    // chopping source, restarts with each run
    pwmGenerator #(
        .pwmPeriod (pwmPeriod),
        .pwmDuty   (pwmDuty)
    ) pwmGenerator_i (
        .clk  (clk),
        .nRst (nRst),
        .run  (cmd.run),
        .pwm  (pwm)
    );

    // chop, set pin polarity, register outputs
    gateDriver gateDriver_i (
        .clk     (clk),
        .nRst    (nRst),
        .gateReq (gateReq),
        .pwm     (pwm),
        .aH      (aH),
        .aL      (aL),
        .bH      (bH),
        .bL      (bL),
        .cH      (cH),
        .cL      (cL)
    );

endmodule

//--- verification/clockGen.sv
module clockGen #(
    // full clock period in ns
    parameter int periodNs    = 8,
    // cycles with nRst held low
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic nRst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #(periodNs / 2) clk = ~clk;

    // reset asserted by a clean falling edge just after time zero
    initial begin
        nRst = 1'b1;
        #1;
        nRst = 1'b0;
        repeat (resetCycles) @(posedge clk);
        // release just after an edge, away from the sampling point
        #1;
        nRst = 1'b1;
    end

endmodule

//--- verification/motorTop_properties.sv
module motorTop_properties (
    input logic clk,
    input logic nRst,
    input logic aH,
    input logic aL,
    input logic bH,
    input logic bL,
    input logic cH,
    input logic cL
);
    timeunit 1ns;
    timeprecision 100ps;

    // no shoot-through on any leg
    // low pins are active low
    phaseAExclusive: assert property (@(posedge clk) disable iff (!nRst) !(aH && !aL))
        else $error("phase a has high and low switch on together");
    phaseBExclusive: assert property (@(posedge clk) disable iff (!nRst) !(bH && !bL))
        else $error("phase b has high and low switch on together");
    phaseCExclusive: assert property (@(posedge clk) disable iff (!nRst) !(cH && !cL))
        else $error("phase c has high and low switch on together");

    // only one high side conducts at a time
    highSideOneHot: assert property (@(posedge clk) disable iff (!nRst) $onehot0({aH, bH, cH}))
        else $error("more than one high-side switch on");

    // same for the low sides
    lowSideOneHot: assert property (@(posedge clk) disable iff (!nRst) $onehot0({~aL, ~bL, ~cL}))
        else $error("more than one low-side switch on");

    // bridge fully off during reset
    idleInReset: assert property (@(posedge clk)
        !nRst |-> (!aH && !bH && !cH && aL && bL && cL))
        else $error("outputs not idle while reset is active");

endmodule

bind motorTop motorTop_properties motorTop_properties_i (
    .clk  (clk),
    .nRst (nRst),
    .aH   (aH),
    .aL   (aL),
    .bH   (bH),
    .bL   (bL),
    .cH   (cH),
    .cL   (cL)
);

//--- verification/motorTb.sv
module motorTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pwmPeriod   = 16;
    localparam int pwmDuty     = 12;
    localparam int clkPeriodNs = 8;
    localparam int resetCycles = 16;
    // run segments, each followed by a stopped gap
    localparam int segCount    = 6;
    localparam int minPeriod   = motorPkg::freqMin;

    logic                           clk;
    logic                           nRst;
    logic                           m3start;
    logic                           m3invOrStop;
    logic [motorPkg::freqWidth-1:0] m3freq;
    logic                           aH;
    logic                           aL;
    logic                           bH;
    logic                           bL;
    logic                           cH;
    logic                           cL;

    integer seed;
    int     errors;
    int     checks;
    longint watchdogNs;

    // planned segments
    int segFreq[segCount];
    int segReverse[segCount];
    int segSteps[segCount];
    int segGap[segCount];

    // model, command stage
    logic cmdRun;
    logic cmdRev;
    int   cmdPeriod;
    // model, sequencer stage
    logic seqRunning;
    logic seqRev;
    int   seqPeriod;
    // cycles since step 0 was entered
    int   seqAge;
    // model, output stage, active-high requests after chopping
    motorPkg::gateT expGate;

    clockGen #(
        .periodNs    (clkPeriodNs),
        .resetCycles (resetCycles)
    ) clockGen_i (
        .clk  (clk),
        .nRst (nRst)
    );

    motorTop #(
        .pwmPeriod (pwmPeriod),
        .pwmDuty   (pwmDuty)
    ) motorTop_i (
        .clk         (clk),
        .nRst        (nRst),
        .m3start     (m3start),
        .m3invOrStop (m3invOrStop),
        .m3freq      (m3freq),
        .aH          (aH),
        .aL          (aL),
        .bH          (bH),
        .bL          (bL),
        .cH          (cH),
        .cL          (cL)
    );

    // uniform in 0 .. n-1
    function automatic int randBelow(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // step length actually used
    function automatic int clampPeriod(input int freq);
        if (freq > minPeriod) begin
            return freq;
        end
        return minPeriod;
    endfunction

    // six-step table, high side first
    // bit pairs are phase a, b, c, each high then low
    function automatic motorPkg::gateT stepPattern(input int s);
        motorPkg::gateT g;
        case (s)
            0:       g = 6'b10_01_00;
            1:       g = 6'b10_00_01;
            2:       g = 6'b00_10_01;
            3:       g = 6'b01_10_00;
            4:       g = 6'b01_00_10;
            default: g = 6'b00_01_10;
        endcase
        return g;
    endfunction

    // gates for a given age into the run
    // pwm frame and step both start at age 0
    function automatic motorPkg::gateT predictGates(input logic running, input int age,
                                                    input int period, input logic rev);
        int stepCount;
        if (!running) begin
            return '0;
        end
        if ((age % pwmPeriod) >= pwmDuty) begin
            return '0;
        end
        stepCount = (age / period) % 6;
        if (rev) begin
            return stepPattern((6 - stepCount) % 6);
        end
        return stepPattern(stepCount);
    endfunction

    // cycle model, stages updated back to front
    always @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            cmdRun     = 1'b0;
            cmdRev     = 1'b0;
            cmdPeriod  = minPeriod;
            seqRunning = 1'b0;
            seqRev     = 1'b0;
            seqPeriod  = minPeriod;
            seqAge     = 0;
            expGate    = '0;
        end else begin
            expGate = predictGates(seqRunning, seqAge, seqPeriod, seqRev);
            if (!cmdRun) begin
                seqRunning = 1'b0;
                seqAge     = 0;
            end else if (!seqRunning) begin
                // run start, step 0 entered
                seqRunning = 1'b1;
                seqAge     = 0;
                seqPeriod  = cmdPeriod;
                seqRev     = cmdRev;
            end else begin
                seqAge++;
            end
            cmdRun    = m3start;
            cmdRev    = m3invOrStop;
            cmdPeriod = clampPeriod(m3freq);
        end
    end

    task automatic checkPin(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s at %0t ns expected %h got %h", name, $time, exp, got);
        end
    endtask

    // compare away from both edges, once the first edge has applied reset
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            checkPin("aH", aH, expGate.aH);
            checkPin("aL", aL, ~expGate.aL);
            checkPin("bH", bH, expGate.bH);
            checkPin("bL", bL, ~expGate.bL);
            checkPin("cH", cH, expGate.cH);
            checkPin("cL", cL, ~expGate.cL);
        end
    end

    // inputs change 1 ns after the edge
    task automatic waitDriveSlot;
        @(posedge clk);
        #1;
    endtask

    // draw every segment up front so the run length is known
    task automatic planSegments;
        longint budget;
        budget = resetCycles + 4;
        for (int i = 0; i < segCount; i++) begin
            // every other segment gets clamped
            if ((i % 2) == 0) begin
                segFreq[i] = randBelow(minPeriod + 1);
            end else begin
                segFreq[i] = minPeriod + 1 + randBelow(1023 - minPeriod);
            end
            segReverse[i] = randBelow(2);
            segSteps[i]   = 7 + randBelow(8);
            segGap[i]     = 20 + randBelow(41);
        end
        // both directions at least once
        segReverse[0] = 0;
        segReverse[1] = 1;
        for (int i = 0; i < segCount; i++) begin
            budget += segSteps[i] * clampPeriod(segFreq[i]) + 4 + segGap[i] + 1;
        end
        watchdogNs = (budget + 500) * clkPeriodNs;
    endtask

    task automatic runSegment(input int i);
        int runCycles;
        // full steps plus the two-cycle pin latency
        runCycles = segSteps[i] * clampPeriod(segFreq[i]) + 2;
        waitDriveSlot();
        m3start     = 1'b1;
        m3invOrStop = (segReverse[i] != 0);
        m3freq      = segFreq[i];
        repeat (runCycles) waitDriveSlot();
    endtask

    // stopped, direction and period wander
    task automatic stopGap(input int i);
        waitDriveSlot();
        m3start = 1'b0;
        repeat (segGap[i]) begin
            m3invOrStop = randBelow(2);
            m3freq      = randBelow(1024);
            waitDriveSlot();
        end
    endtask

    initial begin
        seed        = 63160;
        errors      = 0;
        checks      = 0;
        watchdogNs  = 0;
        m3start     = 1'b0;
        m3invOrStop = 1'b0;
        m3freq      = '0;
        planSegments();
        wait (nRst === 1'b1);
        repeat (4) waitDriveSlot();
        for (int i = 0; i < segCount; i++) begin
            runSegment(i);
            stopGap(i);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, armed once the segments are planned
    initial begin
        wait (watchdogNs > 0);
        #(watchdogNs);
        $display("run timed out after %0d ns before all segments finished", watchdogNs);
        $display("checks %0d, errors %0d", checks, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- build.f
source/motorPkg.sv
source/commandSync.sv
source/commutator.sv
source/pwmGenerator.sv
source/gateDriver.sv
source/motorTop.sv
verification/clockGen.sv
verification/motorTop_properties.sv
verification/motorTb.sv
